//--- Makefile
.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_iagc -f tb.f -o tb_iagc

run: build
	@out=$$(./obj_dir/tb_iagc); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- iagc_assertions.sv
`default_nettype none

module iagc_assertions (
    input logic                                               i_clock,
    input logic                                               i_reset,
    input logic                                               i_write,
    input logic                                               i_full,
    input logic                                               i_valid,
    input logic                                               i_ready,
    input logic [iagc_pkg::ERR_WIDTH - 1:0]                   i_data,
    input logic [$clog2(iagc_pkg::DUMP_CREDIT_MAX + 1) - 1:0] i_credits
);
    timeunit 1ns;
    timeprecision 1ps;
    import iagc_pkg::*;

    a_no_write_when_full: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_write && i_full))
        else $error("Command written into a full queue.");

    a_word_held_until_ready: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_data)))
        else $error("Readback word dropped or changed while not ready.");

    a_credit_limit: assert property (@(posedge i_clock) disable iff (i_reset)
        int'(i_credits) <= DUMP_CREDIT_MAX)
        else $error("Readback credit count above its limit.");

endmodule

bind iagc_cmd_queue iagc_assertions u_queue_assertions (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_write   (i_cmd_valid),
    .i_full    (full),
    .i_valid   (1'b0),
    .i_ready   (1'b0),
    .i_data    ('0),
    .i_credits ('0)
);

bind iagc_dump_tx iagc_assertions u_credit_assertions (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_write   (1'b0),
    .i_full    (1'b0),
    .i_valid   (stream.valid),
    .i_ready   (stream.ready),
    .i_data    (stream.data),
    .i_credits (credits)
);

`default_nettype wire

//--- iagc_cmd_queue.sv
`default_nettype none

module iagc_cmd_queue (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_cmd_valid,
    input  logic [iagc_pkg::CMD_WIDTH - 1:0] i_cmd_op,
    input  logic [iagc_pkg::CMD_WIDTH - 1:0] i_cmd_param,
    output logic                             o_cmd_credit,
    iagc_cmd_if.source                       cmd
);
    import iagc_pkg::*;

    logic [CMD_WIDTH - 1:0]               op_mem    [CMD_QUEUE_DEPTH];
    logic [CMD_WIDTH - 1:0]               param_mem [CMD_QUEUE_DEPTH];
    logic [$clog2(CMD_QUEUE_DEPTH) - 1:0] wr_ptr;
    logic [$clog2(CMD_QUEUE_DEPTH) - 1:0] rd_ptr;
    logic [$clog2(CMD_QUEUE_DEPTH):0]     count;
    logic                                 full;
    logic                                 push;
    logic                                 pop;

    assign full = (count == CMD_QUEUE_DEPTH);
    assign push = i_cmd_valid && !full;
    assign pop  = cmd.pop && cmd.valid;

    assign cmd.valid = (count != '0);
    assign cmd.op    = op_mem[rd_ptr];
    assign cmd.param = param_mem[rd_ptr];

    always_ff @(posedge i_clock) begin
        if (push) begin
            op_mem[wr_ptr]    <= i_cmd_op;
            param_mem[wr_ptr] <= i_cmd_param;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            o_cmd_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            o_cmd_credit <= pop;            // One credit back per command taken.
        end
    end

endmodule

`default_nettype wire

//--- iagc_dump_tx.sv
`default_nettype none

module iagc_dump_tx (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_dump_credit,
    iagc_stream_if.sink                      stream,
    output logic                             o_dump_valid,
    output logic [iagc_pkg::ERR_WIDTH - 1:0] o_dump_data
);
    import iagc_pkg::*;

    logic [$clog2(DUMP_CREDIT_MAX + 1) - 1:0] credits;
    logic                                     xfer;

    assign stream.ready = (credits != '0);
    assign xfer         = stream.valid && stream.ready;

    // A credit arriving with a transfer leaves the count unchanged.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credits <= '0;
        end else if (xfer && !i_dump_credit) begin
            credits <= credits - 1'b1;
        end else if (!xfer && i_dump_credit && credits != DUMP_CREDIT_MAX) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_dump_valid <= 1'b0;
        end else begin
            o_dump_valid <= xfer;
        end
    end

    always_ff @(posedge i_clock) begin
        if (xfer) begin
            o_dump_data <= stream.data;    // Held until the next word.
        end
    end

endmodule

`default_nettype wire

//--- iagc_fsm.sv
`default_nettype none

module iagc_fsm (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_adc_init_done,
    input  logic                                  i_dac_init_done,
    iagc_cmd_if.sink                              cmd,
    iagc_mem_ctrl_if.ctrl                         mem,
    output iagc_pkg::iagc_state_e                 o_status,
    output logic [iagc_pkg::DEC_WIDTH - 1:0]      o_decimator,
    output logic [iagc_pkg::COUNT_WIDTH - 1:0]    o_phase_count,
    output logic [iagc_pkg::COUNT_WIDTH - 1:0]    o_amplitude_count,
    output logic [iagc_pkg::MEM_SIZE_WIDTH - 1:0] o_memory_size
);
    import iagc_pkg::*;

    iagc_state_e                 state;
    iagc_state_e                 next_state;
    iagc_op_e                    cmd_op;
    logic [CMD_WIDTH - 1:0]      cmd_param;
    logic [MEM_SIZE_WIDTH - 1:0] memory_size;
    logic [DEC_WIDTH - 1:0]      decimator;
    logic [COUNT_WIDTH - 1:0]    phase_count;
    logic [COUNT_WIDTH - 1:0]    amplitude_count;

    always_comb begin
        next_state = state;
        case (state)
            RESET:     next_state = INIT;
            INIT:      next_state = (i_adc_init_done && i_dac_init_done) ? IDLE : INIT;
            IDLE:      next_state = cmd.valid ? CMD_PARSE : IDLE;
            CMD_PARSE: next_state = CMD_READ;
            CMD_READ: begin
                case (cmd_op)
                    OP_EMPTY:     next_state = IDLE;
                    OP_RESET:     next_state = RESET;
                    OP_SAMPLE:    next_state = SAMPLE;
                    OP_SET_DEC:   next_state = SET_DEC;
                    OP_CLEAN_MEM: next_state = CLEAN_MEM;
                    OP_DUMP_REF:  next_state = DUMP_REF;
                    OP_DUMP_ERR:  next_state = DUMP_ERR;
                    OP_SET_MEM:   next_state = SET_MEM;
                    OP_SET_PHA:   next_state = SET_PHA;
                    OP_SET_AMP:   next_state = SET_AMP;
                    OP_HALT:      next_state = HALT;
                    default:      next_state = CMD_ERROR;
                endcase
            end
            SAMPLE:    next_state = mem.sample_end ? IDLE : SAMPLE;
            CLEAN_MEM: next_state = mem.clean_end ? IDLE : CLEAN_MEM;
            DUMP_REF,
            DUMP_ERR:  next_state = mem.dump_end ? IDLE : state;
            CMD_ERROR,
            SET_MEM,
            SET_DEC,
            SET_PHA,
            SET_AMP:   next_state = IDLE;
            HALT:      next_state = HALT;         // Only i_reset leaves.
            default:   next_state = RESET;
        endcase
    end

    // Start pulses are high in the first cycle of their state.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state            <= RESET;
            mem.start_sample <= 1'b0;
            mem.start_clean  <= 1'b0;
            mem.start_dump   <= 1'b0;
        end else begin
            state            <= next_state;
            mem.start_sample <= (state == CMD_READ) && (next_state == SAMPLE);
            mem.start_clean  <= (state == CMD_READ) && (next_state == CLEAN_MEM);
            mem.start_dump   <= (state == CMD_READ) && (next_state inside {DUMP_REF, DUMP_ERR});
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == CMD_PARSE) begin
            cmd_op    <= iagc_op_e'(cmd.op);
            cmd_param <= cmd.param;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || state == RESET || state == INIT) begin
            memory_size     <= DEF_MEMORY_SIZE;
            decimator       <= DEF_DECIMATOR;
            phase_count     <= DEF_PHASE_COUNT;
            amplitude_count <= DEF_AMPLITUDE_COUNT;
        end else begin
            case (state)
                SET_MEM: begin
                    memory_size <= (cmd_param > CMD_WIDTH'(ADDR_WIDTH))
                                   ? MEM_SIZE_WIDTH'(MEM_DEPTH)     // Capped at one bank.
                                   : MEM_SIZE_WIDTH'(1) << cmd_param;
                end
                SET_DEC: decimator       <= cmd_param;
                SET_PHA: phase_count     <= COUNT_WIDTH'(1) << cmd_param;
                SET_AMP: amplitude_count <= COUNT_WIDTH'(1) << cmd_param;
                default: ;
            endcase
        end
    end

    assign cmd.pop         = (state == CMD_PARSE);
    assign mem.bank_sel    = (state == DUMP_ERR);
    assign mem.memory_size = memory_size;
    assign mem.decimator   = decimator;
    assign mem.amplitude   = amplitude_count;

    assign o_status          = state;
    assign o_memory_size     = memory_size;
    assign o_decimator       = decimator;
    assign o_phase_count     = phase_count;
    assign o_amplitude_count = amplitude_count;

endmodule

`default_nettype wire

//--- iagc_if.sv
`default_nettype none

interface iagc_cmd_if;
    logic                             valid;
    logic [iagc_pkg::CMD_WIDTH - 1:0] op;
    logic [iagc_pkg::CMD_WIDTH - 1:0] param;
    logic                             pop;

    modport source (output valid, op, param, input pop);
    modport sink   (input valid, op, param, output pop);
endinterface

interface iagc_mem_ctrl_if;
    logic                                  start_sample;
    logic                                  start_clean;
    logic                                  start_dump;
    logic                                  bank_sel;    // High selects the error bank.
    logic [iagc_pkg::MEM_SIZE_WIDTH - 1:0] memory_size;
    logic [iagc_pkg::DEC_WIDTH - 1:0]      decimator;
    logic [iagc_pkg::COUNT_WIDTH - 1:0]    amplitude;
    logic                                  sample_end;
    logic                                  clean_end;
    logic                                  dump_end;

    modport ctrl (
        output start_sample, start_clean, start_dump, bank_sel,
        output memory_size, decimator, amplitude,
        input  sample_end, clean_end, dump_end
    );
    modport mem (
        input  start_sample, start_clean, start_dump, bank_sel,
        input  memory_size, decimator, amplitude,
        output sample_end, clean_end, dump_end
    );
endinterface

interface iagc_stream_if;
    logic                             valid;
    logic [iagc_pkg::ERR_WIDTH - 1:0] data;
    logic                             ready;

    modport source (output valid, data, input ready);
    modport sink   (input valid, data, output ready);
endinterface

`default_nettype wire

//--- iagc_pkg.sv
`default_nettype none

package iagc_pkg;

    localparam int CMD_WIDTH       = 4;
    localparam int ADC_WIDTH       = 14;
    localparam int ERR_WIDTH       = 16;           // Error and readback word.
    localparam int MEM_DEPTH       = 256;
    localparam int ADDR_WIDTH      = 8;
    localparam int MEM_SIZE_WIDTH  = 9;            // Holds MEM_DEPTH itself.
    localparam int DEC_WIDTH       = 4;
    localparam int COUNT_WIDTH     = 16;
    localparam int CMD_QUEUE_DEPTH = 4;            // Initial host credits.
    localparam int DUMP_CREDIT_MAX = 8;

    localparam logic [MEM_SIZE_WIDTH - 1:0] DEF_MEMORY_SIZE     = 64;
    localparam logic [DEC_WIDTH - 1:0]      DEF_DECIMATOR       = 4;
    localparam logic [COUNT_WIDTH - 1:0]    DEF_PHASE_COUNT     = 256;
    localparam logic [COUNT_WIDTH - 1:0]    DEF_AMPLITUDE_COUNT = 256;

    // Also the o_status encoding.
    typedef enum logic [3:0] {
        RESET     = 4'd0,
        INIT      = 4'd1,
        IDLE      = 4'd2,
        SAMPLE    = 4'd3,
        CMD_PARSE = 4'd4,
        CMD_READ  = 4'd5,
        CMD_ERROR = 4'd6,
        DUMP_REF  = 4'd7,
        DUMP_ERR  = 4'd8,
        CLEAN_MEM = 4'd9,
        SET_MEM   = 4'd10,
        SET_DEC   = 4'd11,
        SET_PHA   = 4'd12,
        SET_AMP   = 4'd13,
        HALT      = 4'd14
    } iagc_state_e;

    // Codes 11 to 15 are invalid.
    typedef enum logic [3:0] {
        OP_EMPTY     = 4'd0,
        OP_RESET     = 4'd1,
        OP_SAMPLE    = 4'd2,
        OP_SET_DEC   = 4'd3,
        OP_CLEAN_MEM = 4'd4,
        OP_DUMP_REF  = 4'd5,
        OP_DUMP_ERR  = 4'd6,
        OP_SET_MEM   = 4'd7,
        OP_SET_PHA   = 4'd8,
        OP_SET_AMP   = 4'd9,
        OP_HALT      = 4'd10
    } iagc_op_e;

endpackage

`default_nettype wire

//--- iagc_sample_mem.sv
`default_nettype none

module iagc_sample_mem (
    input  logic                             i_clock,
    input  logic                             i_reset,
    input  logic                             i_adc_valid,
    input  logic [iagc_pkg::ADC_WIDTH - 1:0] i_adc_data,
    iagc_mem_ctrl_if.mem                     ctrl,
    iagc_stream_if.source                    stream
);
    import iagc_pkg::*;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_SAMPLE,
        MODE_CLEAN,
        MODE_DUMP
    } mode_e;

    logic [ADC_WIDTH - 1:0]  ref_mem [MEM_DEPTH];
    logic [ERR_WIDTH - 1:0]  err_mem [MEM_DEPTH];
    mode_e                   mode;
    logic [ADDR_WIDTH - 1:0] addr;
    logic [DEC_WIDTH - 1:0]  dec_cnt;
    logic [DEC_WIDTH - 1:0]  dec_last;
    logic                    bank;
    logic                    keep;
    logic                    wr_en;
    logic                    last_word;
    logic                    xfer;
    logic [ADC_WIDTH - 1:0]  wr_ref;
    logic [ERR_WIDTH - 1:0]  wr_err;

    assign dec_last  = (ctrl.decimator == '0) ? '0 : ctrl.decimator - 1'b1;  // 0 acts as 1.
    assign keep      = (mode == MODE_SAMPLE) && i_adc_valid && (dec_cnt == '0);
    assign wr_en     = keep || (mode == MODE_CLEAN);
    assign last_word = (MEM_SIZE_WIDTH'(addr) == ctrl.memory_size - 1'b1);
    assign xfer      = stream.valid && stream.ready;

    // Samples are unsigned; the error wraps to ERR_WIDTH.
    assign wr_ref = (mode == MODE_CLEAN) ? '0 : i_adc_data;
    assign wr_err = (mode == MODE_CLEAN) ? '0 : ERR_WIDTH'(i_adc_data) - ctrl.amplitude;

    assign stream.valid = (mode == MODE_DUMP);
    assign stream.data  = bank ? err_mem[addr] : ERR_WIDTH'(ref_mem[addr]);

    always_ff @(posedge i_clock) begin
        if (wr_en) begin
            ref_mem[addr] <= wr_ref;
            err_mem[addr] <= wr_err;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            mode            <= MODE_IDLE;
            addr            <= '0;
            dec_cnt         <= '0;
            bank            <= 1'b0;
            ctrl.sample_end <= 1'b0;
            ctrl.clean_end  <= 1'b0;
            ctrl.dump_end   <= 1'b0;
        end else begin
            ctrl.sample_end <= 1'b0;
            ctrl.clean_end  <= 1'b0;
            ctrl.dump_end   <= 1'b0;
            case (mode)
                MODE_IDLE: begin
                    addr    <= '0;
                    dec_cnt <= '0;
                    if (ctrl.start_sample) begin
                        mode <= MODE_SAMPLE;
                    end else if (ctrl.start_clean) begin
                        mode <= MODE_CLEAN;
                    end else if (ctrl.start_dump) begin
                        mode <= MODE_DUMP;
                        bank <= ctrl.bank_sel;
                    end
                end
                MODE_SAMPLE: begin
                    if (i_adc_valid) begin
                        dec_cnt <= (dec_cnt == dec_last) ? '0 : dec_cnt + 1'b1;
                    end
                    if (keep) begin
                        addr <= addr + 1'b1;
                        if (last_word) begin
                            mode            <= MODE_IDLE;
                            ctrl.sample_end <= 1'b1;
                        end
                    end
                end
                MODE_CLEAN: begin
                    addr <= addr + 1'b1;               // Sweeps both full banks.
                    if (addr == ADDR_WIDTH'(MEM_DEPTH - 1)) begin
                        mode           <= MODE_IDLE;
                        ctrl.clean_end <= 1'b1;
                    end
                end
                MODE_DUMP: begin
                    if (xfer) begin
                        addr <= addr + 1'b1;
                        if (last_word) begin
                            mode          <= MODE_IDLE;
                            ctrl.dump_end <= 1'b1;
                        end
                    end
                end
                default: mode <= MODE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- iagc_top.sv
`default_nettype none

module iagc_top (
    input  logic                                  i_clock,
    input  logic                                  i_reset,
    input  logic                                  i_cmd_valid,
    input  logic [iagc_pkg::CMD_WIDTH - 1:0]      i_cmd_op,
    input  logic [iagc_pkg::CMD_WIDTH - 1:0]      i_cmd_param,
    output logic                                  o_cmd_credit,
    input  logic                                  i_adc_valid,
    input  logic [iagc_pkg::ADC_WIDTH - 1:0]      i_adc_data,
    input  logic                                  i_adc_init_done,
    input  logic                                  i_dac_init_done,
    output logic                                  o_dump_valid,
    output logic [iagc_pkg::ERR_WIDTH - 1:0]      o_dump_data,
    input  logic                                  i_dump_credit,
    output iagc_pkg::iagc_state_e                 o_status,
    output logic [iagc_pkg::DEC_WIDTH - 1:0]      o_decimator,
    output logic [iagc_pkg::COUNT_WIDTH - 1:0]    o_phase_count,
    output logic [iagc_pkg::COUNT_WIDTH - 1:0]    o_amplitude_count,
    output logic [iagc_pkg::MEM_SIZE_WIDTH - 1:0] o_memory_size
);

    iagc_cmd_if      cmd_bus ();
    iagc_mem_ctrl_if mem_bus ();
    iagc_stream_if   stream_bus ();

    iagc_cmd_queue u_cmd_queue (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_param  (i_cmd_param),
        .o_cmd_credit (o_cmd_credit),
        .cmd          (cmd_bus.source)
    );

    iagc_fsm u_fsm (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_adc_init_done   (i_adc_init_done),
        .i_dac_init_done   (i_dac_init_done),
        .cmd               (cmd_bus.sink),
        .mem               (mem_bus.ctrl),
        .o_status          (o_status),
        .o_decimator       (o_decimator),
        .o_phase_count     (o_phase_count),
        .o_amplitude_count (o_amplitude_count),
        .o_memory_size     (o_memory_size)
    );

    iagc_sample_mem u_sample_mem (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_adc_valid (i_adc_valid),
        .i_adc_data  (i_adc_data),
        .ctrl        (mem_bus.mem),
        .stream      (stream_bus.source)
    );

    iagc_dump_tx u_dump_tx (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_dump_credit (i_dump_credit),
        .stream        (stream_bus.sink),
        .o_dump_valid  (o_dump_valid),
        .o_dump_data   (o_dump_data)
    );

endmodule

`default_nettype wire

//--- tb.f
iagc_pkg.sv
iagc_if.sv
iagc_cmd_queue.sv
iagc_fsm.sv
iagc_sample_mem.sv
iagc_dump_tx.sv
iagc_top.sv
iagc_assertions.sv
tb_iagc.sv

//--- tb_iagc.sv
`default_nettype none

module tb_iagc;
    timeunit 1ns;
    timeprecision 1ps;
    import iagc_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int N_RANDOM       = 40;
    localparam int N_CMDS         = 3 * N_RANDOM + 20;
    localparam int MAX_CMD_CYCLES = MEM_DEPTH * 16 * 4;   // Full capture at top decimation.
    localparam int WATCHDOG_NS    = N_CMDS * MAX_CMD_CYCLES * CLK_PERIOD;

    logic                        i_clock;
    logic                        i_reset;
    logic                        i_cmd_valid;
    logic [CMD_WIDTH - 1:0]      i_cmd_op;
    logic [CMD_WIDTH - 1:0]      i_cmd_param;
    logic                        o_cmd_credit;
    logic                        i_adc_valid;
    logic [ADC_WIDTH - 1:0]      i_adc_data;
    logic                        i_adc_init_done;
    logic                        i_dac_init_done;
    logic                        o_dump_valid;
    logic [ERR_WIDTH - 1:0]      o_dump_data;
    logic                        i_dump_credit;
    iagc_state_e                 o_status;
    logic [DEC_WIDTH - 1:0]      o_decimator;
    logic [COUNT_WIDTH - 1:0]    o_phase_count;
    logic [COUNT_WIDTH - 1:0]    o_amplitude_count;
    logic [MEM_SIZE_WIDTH - 1:0] o_memory_size;

    logic [MEM_SIZE_WIDTH - 1:0] m_mem_size;
    logic [DEC_WIDTH - 1:0]      m_dec;
    logic [COUNT_WIDTH - 1:0]    m_pha;
    logic [COUNT_WIDTH - 1:0]    m_amp;
    logic [ERR_WIDTH - 1:0]      ref_model [MEM_DEPTH];
    logic [ERR_WIDTH - 1:0]      err_model [MEM_DEPTH];
    logic [ERR_WIDTH - 1:0]      dump_q [$];
    int                          host_credits;
    int                          credit_returns;
    int                          cmds_sent;
    int                          errors;
    int                          checks;
    bit                          credit_en;

    iagc_top u_iagc_top (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_cmd_valid       (i_cmd_valid),
        .i_cmd_op          (i_cmd_op),
        .i_cmd_param       (i_cmd_param),
        .o_cmd_credit      (o_cmd_credit),
        .i_adc_valid       (i_adc_valid),
        .i_adc_data        (i_adc_data),
        .i_adc_init_done   (i_adc_init_done),
        .i_dac_init_done   (i_dac_init_done),
        .o_dump_valid      (o_dump_valid),
        .o_dump_data       (o_dump_data),
        .i_dump_credit     (i_dump_credit),
        .o_status          (o_status),
        .o_decimator       (o_decimator),
        .o_phase_count     (o_phase_count),
        .o_amplitude_count (o_amplitude_count),
        .o_memory_size     (o_memory_size)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all commands completed");
        $display("TEST FAILED");
        $finish;
    end

    // Host side of both credit links.
    always @(negedge i_clock) begin
        if (o_cmd_credit) begin
            host_credits++;
            credit_returns++;
        end
        if (o_dump_valid) begin
            dump_q.push_back(o_dump_data);
        end
        i_dump_credit = credit_en ? 1'($urandom_range(0, 1)) : 1'b0;
    end

    task automatic check_eq(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic load_defaults();
        m_mem_size = DEF_MEMORY_SIZE;
        m_dec      = DEF_DECIMATOR;
        m_pha      = DEF_PHASE_COUNT;
        m_amp      = DEF_AMPLITUDE_COUNT;
    endtask

    task automatic check_regs();
        check_eq("memory size", o_memory_size, m_mem_size);
        check_eq("decimator", o_decimator, m_dec);
        check_eq("phase count", o_phase_count, m_pha);
        check_eq("amplitude count", o_amplitude_count, m_amp);
    endtask

    task automatic send_cmd(input logic [CMD_WIDTH - 1:0] op, input logic [CMD_WIDTH - 1:0] param);
        int waited;
        waited = 0;
        while (host_credits == 0 && waited < MAX_CMD_CYCLES) begin
            @(negedge i_clock);
            waited++;
        end
        if (host_credits == 0) begin
            errors++;
            $display("Host ran out of command credits, none came back");
        end else begin
            i_cmd_valid = 1'b1;
            i_cmd_op    = op;
            i_cmd_param = param;
            host_credits--;
            cmds_sent++;
            @(negedge i_clock);
            i_cmd_valid = 1'b0;
        end
    endtask

    // Returns once the FSM has left IDLE and then reached target.
    task automatic wait_state(input iagc_state_e target, output logic [15:0] seen);
        int n;
        bit left;
        seen = '0;
        n    = 0;
        left = (o_status != IDLE);
        while (!(left && o_status == target) && n < MAX_CMD_CYCLES) begin
            @(negedge i_clock);
            n++;
            seen[o_status] = 1'b1;
            if (o_status != IDLE) begin
                left = 1'b1;
            end
        end
        if (o_status != target) begin
            errors++;
            $display("Timed out waiting for the FSM to reach %s", target.name());
        end
    endtask

    task automatic run_cmd(input logic [CMD_WIDTH - 1:0] op, input logic [CMD_WIDTH - 1:0] param);
        logic [15:0] seen;
        send_cmd(op, param);
        wait_state(IDLE, seen);
        case (op)
            OP_SET_MEM: m_mem_size = (param > 8) ? MEM_SIZE_WIDTH'(MEM_DEPTH) : 9'd1 << param;
            OP_SET_DEC: m_dec = param;
            OP_SET_PHA: m_pha = 16'd1 << param;
            OP_SET_AMP: m_amp = 16'd1 << param;
            OP_RESET:   load_defaults();
            default: ;
        endcase
        check_eq("CMD_ERROR visited", seen[CMD_ERROR], op > 4'(OP_HALT));
        check_regs();
    endtask

    task automatic capture();
        logic [15:0]            seen;
        logic [ADC_WIDTH - 1:0] sample;
        int                     stored;
        int                     vcount;
        int                     dec_eff;
        stored  = 0;
        vcount  = 0;
        dec_eff = (m_dec == 0) ? 1 : int'(m_dec);
        send_cmd(OP_SAMPLE, 4'd0);
        wait_state(SAMPLE, seen);
        @(negedge i_clock);                  // Start pulse cycle.
        while (stored < int'(m_mem_size)) begin
            sample      = ADC_WIDTH'($urandom);
            i_adc_valid = 1'($urandom_range(0, 1));
            i_adc_data  = sample;
            if (i_adc_valid) begin
                if (vcount % dec_eff == 0) begin
                    ref_model[stored] = ERR_WIDTH'(sample);
                    err_model[stored] = ERR_WIDTH'(sample) - m_amp;
                    stored++;
                end
                vcount++;
            end
            @(negedge i_clock);
        end
        i_adc_valid = 1'b0;
        wait_state(IDLE, seen);
    endtask

    task automatic compare_dump(input bit err_bank);
        logic [ERR_WIDTH - 1:0] expected;
        check_eq("readback word count", dump_q.size(), m_mem_size);
        for (int i = 0; i < dump_q.size() && i < int'(m_mem_size); i++) begin
            expected = err_bank ? err_model[i] : ref_model[i];
            check_eq($sformatf("readback word %0d", i), dump_q[i], expected);
        end
    endtask

    task automatic dump_check(input bit err_bank);
        logic [15:0] seen;
        dump_q.delete();
        send_cmd(err_bank ? OP_DUMP_ERR : OP_DUMP_REF, 4'd0);
        wait_state(IDLE, seen);
        compare_dump(err_bank);
    endtask

    task automatic clean_check();
        run_cmd(OP_CLEAN_MEM, 4'd0);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_model[i] = '0;
            err_model[i] = '0;
        end
        dump_check(1'($urandom_range(0, 1)));
    endtask

    task automatic stall_check();
        logic [15:0] seen;
        int          held;
        run_cmd(OP_SET_MEM, 4'd6);
        credit_en = 1'b0;
        dump_q.delete();
        send_cmd(OP_DUMP_ERR, 4'd0);
        repeat (100) @(negedge i_clock);
        held = dump_q.size();
        check_eq("words sent on leftover credits", held <= DUMP_CREDIT_MAX, 1);
        check_eq("status while stalled", o_status, DUMP_ERR);
        repeat (20) @(negedge i_clock);
        check_eq("words sent while stalled", dump_q.size(), held);
        credit_en = 1'b1;
        wait_state(IDLE, seen);
        compare_dump(1'b1);
    endtask

    task automatic halt_check();
        logic [15:0] seen;
        send_cmd(OP_HALT, 4'($urandom));
        wait_state(HALT, seen);
        check_eq("command credits returned", credit_returns, cmds_sent);
        send_cmd(OP_SET_DEC, 4'd9);          // Must stay queued.
        repeat (20) begin
            @(negedge i_clock);
            check_eq("status in HALT", o_status, HALT);
        end
        check_regs();
    endtask

    task automatic reset_and_init();
        i_reset         = 1'b1;
        i_cmd_valid     = 1'b0;
        i_adc_valid     = 1'b0;
        i_adc_init_done = 1'b0;
        i_dac_init_done = 1'b0;
        repeat (5) begin
            @(negedge i_clock);
            check_eq("status in reset", o_status, RESET);
            check_eq("command credit in reset", o_cmd_credit, 0);
            check_eq("readback valid in reset", o_dump_valid, 0);
        end
        i_reset        = 1'b0;
        host_credits   = CMD_QUEUE_DEPTH;
        credit_returns = 0;
        cmds_sent      = 0;
        repeat (8) begin
            @(negedge i_clock);
            check_eq("status before init done", o_status, INIT);
            if (o_status == INIT) begin
                i_adc_init_done = 1'b1;      // DAC side still busy.
            end
        end
        i_dac_init_done = 1'b1;
        @(negedge i_clock);
        check_eq("status after init done", o_status, IDLE);
        load_defaults();
        check_regs();
    endtask

    initial begin
        void'($urandom(56));
        i_reset         = 1'b1;
        i_cmd_valid     = 1'b0;
        i_cmd_op        = '0;
        i_cmd_param     = '0;
        i_adc_valid     = 1'b0;
        i_adc_data      = '0;
        i_adc_init_done = 1'b0;
        i_dac_init_done = 1'b0;
        i_dump_credit   = 1'b0;
        credit_en       = 1'b1;
        errors          = 0;
        checks          = 0;
        reset_and_init();
        clean_check();
        run_cmd(OP_SET_DEC, 4'($urandom));
        capture();
        dump_check(1'b0);
        dump_check(1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            case ($urandom_range(0, 7))
                0: run_cmd(OP_SET_MEM, 4'($urandom));
                1: run_cmd(OP_SET_DEC, 4'($urandom));
                2: run_cmd(OP_SET_PHA, 4'($urandom));
                3: run_cmd(OP_SET_AMP, 4'($urandom));
                4: run_cmd(OP_RESET, 4'($urandom));
                5: run_cmd(($urandom_range(0, 3) == 0) ? 4'(OP_EMPTY) : 4'($urandom_range(11, 15)),
                           4'($urandom));
                6: begin
                    capture();
                    dump_check(1'b0);
                    dump_check(1'b1);
                end
                default: clean_check();
            endcase
        end
        stall_check();
        halt_check();
        reset_and_init();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
